/* Bender.yml */
package:
  name: pinmux

sources:
  - hdl/pinmux_bus_pkg.sv
  - hdl/pinmux_pkg.sv
  - hdl/pinmux_regs.sv
  - hdl/pinmux_pad_mux.sv
  - hdl/pinmux_wkup.sv
  - hdl/pinmux.sv
  - target: simulation
    files:
      - verification/pinmux_sva.sv
      - verification/pinmux_tb.sv

/* hdl/pinmux.sv */
// Pad multiplexer top level with register slave, pad muxes and wakeup detectors
`default_nettype none

module pinmux
  import pinmux_bus_pkg::*;
  import pinmux_pkg::*;
#(
  // Selects must hold NPeriphOut+3 and NMioPads+2 codes
  parameter int NMioPads    = 8,
  parameter int NDioPads    = 4,
  parameter int NPeriphIn   = 6,
  parameter int NPeriphOut  = 6,
  parameter int NWkupDetect = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           sleep_en_i,
  input  wb_req_t                        wb_req_i,
  output wb_rsp_t                        wb_rsp_o,
  // Peripheral side
  input  logic [NPeriphOut-1:0]          periph_to_mio_i,
  input  logic [NPeriphOut-1:0]          periph_to_mio_oe_i,
  output logic [NPeriphIn-1:0]           mio_to_periph_o,
  input  logic [NDioPads-1:0]            periph_to_dio_i,
  input  logic [NDioPads-1:0]            periph_to_dio_oe_i,
  output logic [NDioPads-1:0]            dio_to_periph_o,
  // Pad side
  output logic [NMioPads-1:0]            mio_out_o,
  output logic [NMioPads-1:0]            mio_oe_o,
  output logic [NMioPads-1:0][AttrW-1:0] mio_attr_o,
  input  logic [NMioPads-1:0]            mio_in_i,
  output logic [NDioPads-1:0]            dio_out_o,
  output logic [NDioPads-1:0]            dio_oe_o,
  output logic [NDioPads-1:0][AttrW-1:0] dio_attr_o,
  input  logic [NDioPads-1:0]            dio_in_i,
  output logic                           aon_wkup_req_o
);

  localparam int PadMuxW = 2 ** SelW;

  logic [NPeriphIn-1:0][SelW-1:0] insel;
  mio_pad_cfg_t [NMioPads-1:0]    mio_cfg;
  dio_pad_cfg_t [NDioPads-1:0]    dio_cfg;
  wkup_cfg_t [NWkupDetect-1:0]    wkup_cfg;
  logic [NMioPads+NDioPads-1:0]   sleep_status;
  logic [NMioPads-1:0]            mio_sleep_set;
  logic [NDioPads-1:0]            dio_sleep_set;
  logic [NWkupDetect-1:0]         wkup_cause, wkup_clr;
  logic [PadMuxW-1:0]             mio_wkup_mux, dio_wkup_mux;

  pinmux_regs #(
    .NMioPads    (NMioPads),
    .NDioPads    (NDioPads),
    .NPeriphIn   (NPeriphIn),
    .NWkupDetect (NWkupDetect)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .wb_req_i,
    .wb_rsp_o,
    .sleep_en_i,
    .insel_o         (insel),
    .mio_cfg_o       (mio_cfg),
    .dio_cfg_o       (dio_cfg),
    .wkup_cfg_o      (wkup_cfg),
    .sleep_status_o  (sleep_status),
    .mio_sleep_set_i (mio_sleep_set),
    .dio_sleep_set_i (dio_sleep_set),
    .wkup_cause_i    (wkup_cause),
    .wkup_clr_o      (wkup_clr)
  );

  pinmux_pad_mux #(
    .NMioPads   (NMioPads),
    .NDioPads   (NDioPads),
    .NPeriphIn  (NPeriphIn),
    .NPeriphOut (NPeriphOut)
  ) u_pad_mux (
    .clk_i,
    .rst_ni,
    .sleep_en_i,
    .insel_i         (insel),
    .mio_cfg_i       (mio_cfg),
    .dio_cfg_i       (dio_cfg),
    .sleep_status_i  (sleep_status),
    .mio_sleep_set_o (mio_sleep_set),
    .dio_sleep_set_o (dio_sleep_set),
    .periph_to_mio_i,
    .periph_to_mio_oe_i,
    .mio_to_periph_o,
    .periph_to_dio_i,
    .periph_to_dio_oe_i,
    .dio_to_periph_o,
    .mio_out_o,
    .mio_oe_o,
    .mio_attr_o,
    .mio_in_i,
    .dio_out_o,
    .dio_oe_o,
    .dio_attr_o,
    .dio_in_i
  );

  ////////////////////////////////////////
  // Wakeup detectors
  ////////////////////////////////////////

  // Raw pad inputs, padded out to the select range
  assign mio_wkup_mux = PadMuxW'(mio_in_i);
  assign dio_wkup_mux = PadMuxW'(dio_in_i);

  for (genvar k = 0; k < NWkupDetect; k++) begin : gen_wkup
    logic pin_value;

    assign pin_value = wkup_cfg[k].is_dio ? dio_wkup_mux[wkup_cfg[k].padsel] :
                                            mio_wkup_mux[wkup_cfg[k].padsel];

    pinmux_wkup u_wkup (
      .clk_i,
      .rst_ni,
      .cfg_i       (wkup_cfg[k]),
      .pin_value_i (pin_value),
      .cause_clr_i (wkup_clr[k]),
      .cause_o     (wkup_cause[k])
    );
  end

  // Any pending cause requests wakeup
  assign aon_wkup_req_o = |wkup_cause;

endmodule

`default_nettype wire

/* hdl/pinmux_bus_pkg.sv */
// Wishbone classic bus types and the register address map of the pad multiplexer
`default_nettype none

package pinmux_bus_pkg;

  ////////////////////////////////////////
  // Wishbone structs
  ////////////////////////////////////////

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  ////////////////////////////////////////
  // Register map, byte addresses
  ////////////////////////////////////////

  // Arrays with one word per entry
  localparam logic [7:0] MioInselBase    = 8'h00;
  localparam logic [7:0] MioPadBase      = 8'h40;
  localparam logic [7:0] DioPadBase      = 8'h80;
  localparam logic [7:0] WkupBase        = 8'hC0;
  // Single words at the top of the map
  localparam logic [7:0] WkupCauseAddr   = 8'hF0;
  localparam logic [7:0] SleepStatusAddr = 8'hF4;
  localparam logic [7:0] SleepEnAddr     = 8'hF8;

endpackage

`default_nettype wire

/* hdl/pinmux_pad_mux.sv */
// Pad input and output muxing, dedicated passthrough and sleep retention
`default_nettype none

module pinmux_pad_mux
  import pinmux_pkg::*;
#(
  parameter int NMioPads   = 8,
  parameter int NDioPads   = 4,
  parameter int NPeriphIn  = 6,
  parameter int NPeriphOut = 6
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             sleep_en_i,
  input  logic [NPeriphIn-1:0][SelW-1:0]   insel_i,
  input  mio_pad_cfg_t [NMioPads-1:0]      mio_cfg_i,
  input  dio_pad_cfg_t [NDioPads-1:0]      dio_cfg_i,
  input  logic [NMioPads+NDioPads-1:0]     sleep_status_i,
  output logic [NMioPads-1:0]              mio_sleep_set_o,
  output logic [NDioPads-1:0]              dio_sleep_set_o,
  input  logic [NPeriphOut-1:0]            periph_to_mio_i,
  input  logic [NPeriphOut-1:0]            periph_to_mio_oe_i,
  output logic [NPeriphIn-1:0]             mio_to_periph_o,
  input  logic [NDioPads-1:0]              periph_to_dio_i,
  input  logic [NDioPads-1:0]              periph_to_dio_oe_i,
  output logic [NDioPads-1:0]              dio_to_periph_o,
  output logic [NMioPads-1:0]              mio_out_o,
  output logic [NMioPads-1:0]              mio_oe_o,
  output logic [NMioPads-1:0][AttrW-1:0]   mio_attr_o,
  input  logic [NMioPads-1:0]              mio_in_i,
  output logic [NDioPads-1:0]              dio_out_o,
  output logic [NDioPads-1:0]              dio_oe_o,
  output logic [NDioPads-1:0][AttrW-1:0]   dio_attr_o,
  input  logic [NDioPads-1:0]              dio_in_i
);

  // Full decode of a select field, unused codes give 0
  localparam int MuxW = 2 ** SelW;

  logic [MuxW-1:0] out_mux, oe_mux, in_mux;
  logic            sleep_q, sleep_qq, sleep_trig;

  // Retention value as {oe, out}
  function automatic logic [1:0] ret_val(sleep_mode_e mode, logic out, logic oe);
    logic [1:0] val;
    case (mode)
      SleepLow:   val = 2'b10;
      SleepHigh:  val = 2'b11;
      SleepHighZ: val = 2'b00;
      default:    val = {oe, out};
    endcase
    return val;
  endfunction

  ////////////////////////////////////////
  // Sleep entry
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q  <= 1'b0;
      sleep_qq <= 1'b0;
    end else begin
      sleep_q  <= sleep_en_i;
      sleep_qq <= sleep_q;
    end
  end

  // One cycle after the registered rising edge
  assign sleep_trig = sleep_q & ~sleep_qq;

  ////////////////////////////////////////
  // Muxed pads
  ////////////////////////////////////////

  // Codes 0 high-Z, 1 drive 0, 2 drive 1, 3+j peripheral j
  assign out_mux = MuxW'({periph_to_mio_i, 1'b1, 1'b0, 1'b0});
  assign oe_mux  = MuxW'({periph_to_mio_oe_i, 1'b1, 1'b1, 1'b0});
  // Codes 0 reads 0, 1 reads 1, 2+k pad k
  assign in_mux  = MuxW'({mio_in_i, 1'b1, 1'b0});

  for (genvar k = 0; k < NPeriphIn; k++) begin : gen_insel
    assign mio_to_periph_o[k] = in_mux[insel_i[k]];
  end

  for (genvar k = 0; k < NMioPads; k++) begin : gen_mio
    logic [1:0] ret_d;
    logic       ret_out_q, ret_oe_q;

    // Retained value shown while status is set
    assign mio_out_o[k] = sleep_status_i[k] ? ret_out_q : out_mux[mio_cfg_i[k].outsel];
    assign mio_oe_o[k]  = sleep_status_i[k] ? ret_oe_q : oe_mux[mio_cfg_i[k].outsel];
    assign mio_attr_o[k] = mio_cfg_i[k].attr;

    assign ret_d = ret_val(mio_cfg_i[k].sleep_mode, mio_out_o[k], mio_oe_o[k]);
    assign mio_sleep_set_o[k] = sleep_trig & mio_cfg_i[k].sleep_en;

    always_ff @(posedge clk_i) begin
      if (mio_sleep_set_o[k]) begin
        {ret_oe_q, ret_out_q} <= ret_d;
      end
    end
  end

  ////////////////////////////////////////
  // Dedicated pads
  ////////////////////////////////////////

  assign dio_to_periph_o = dio_in_i;

  for (genvar k = 0; k < NDioPads; k++) begin : gen_dio
    logic [1:0] ret_d;
    logic       ret_out_q, ret_oe_q;

    // Status bits of dedicated pads sit above the muxed ones
    assign dio_out_o[k] = sleep_status_i[NMioPads+k] ? ret_out_q : periph_to_dio_i[k];
    assign dio_oe_o[k]  = sleep_status_i[NMioPads+k] ? ret_oe_q : periph_to_dio_oe_i[k];
    assign dio_attr_o[k] = dio_cfg_i[k].attr;

    assign ret_d = ret_val(dio_cfg_i[k].sleep_mode, dio_out_o[k], dio_oe_o[k]);
    assign dio_sleep_set_o[k] = sleep_trig & dio_cfg_i[k].sleep_en;

    always_ff @(posedge clk_i) begin
      if (dio_sleep_set_o[k]) begin
        {ret_oe_q, ret_out_q} <= ret_d;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/pinmux_pkg.sv */
// Pad, sleep and wakeup configuration types of the pad multiplexer
`default_nettype none

package pinmux_pkg;

  // Width of every insel, outsel and padsel field
  localparam int SelW  = 4;
  // Pad attribute width
  localparam int AttrW = 4;
  // Timed wakeup threshold width
  localparam int CntW  = 8;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SleepLow   = 2'd0,
    SleepHigh  = 2'd1,
    SleepHighZ = 2'd2,
    SleepKeep  = 2'd3
  } sleep_mode_e;

  typedef enum logic [2:0] {
    WkupPosedge   = 3'd0,
    WkupNegedge   = 3'd1,
    WkupEdge      = 3'd2,
    WkupTimedHigh = 3'd3,
    WkupTimedLow  = 3'd4
  } wkup_mode_e;

  ////////////////////////////////////////
  // Register word layouts, MSB first
  ////////////////////////////////////////

  // Word bits 10:7 attr, 6:5 mode, 4 sleep_en, 3:0 outsel
  typedef struct packed {
    logic [AttrW-1:0] attr;
    sleep_mode_e      sleep_mode;
    logic             sleep_en;
    logic [SelW-1:0]  outsel;
  } mio_pad_cfg_t;

  // Word bits 6:3 attr, 2:1 mode, 0 sleep_en
  typedef struct packed {
    logic [AttrW-1:0] attr;
    sleep_mode_e      sleep_mode;
    logic             sleep_en;
  } dio_pad_cfg_t;

  // Word bits 17:10 cnt_th, 9:6 padsel, 5 is_dio, 4 filter, 3:1 mode, 0 en
  typedef struct packed {
    logic [CntW-1:0] cnt_th;
    logic [SelW-1:0] padsel;
    logic            is_dio;
    logic            filter;
    wkup_mode_e      mode;
    logic            en;
  } wkup_cfg_t;

endpackage

`default_nettype wire

/* hdl/pinmux_regs.sv */
// Wishbone classic register slave holding pad, sleep and wakeup configuration
`default_nettype none

module pinmux_regs
  import pinmux_bus_pkg::*;
  import pinmux_pkg::*;
#(
  parameter int NMioPads    = 8,
  parameter int NDioPads    = 4,
  parameter int NPeriphIn   = 6,
  parameter int NWkupDetect = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  wb_req_t                             wb_req_i,
  output wb_rsp_t                             wb_rsp_o,
  input  logic                                sleep_en_i,
  output logic [NPeriphIn-1:0][SelW-1:0]      insel_o,
  output mio_pad_cfg_t [NMioPads-1:0]         mio_cfg_o,
  output dio_pad_cfg_t [NDioPads-1:0]         dio_cfg_o,
  output wkup_cfg_t [NWkupDetect-1:0]         wkup_cfg_o,
  output logic [NMioPads+NDioPads-1:0]        sleep_status_o,
  input  logic [NMioPads-1:0]                 mio_sleep_set_i,
  input  logic [NDioPads-1:0]                 dio_sleep_set_i,
  input  logic [NWkupDetect-1:0]              wkup_cause_i,
  output logic [NWkupDetect-1:0]              wkup_clr_o
);

  localparam int NPads = NMioPads + NDioPads;

  logic                          access, wr_en, ack_q;
  logic [7:0]                    adr;
  logic [3:0]                    idx;
  logic [31:0]                   wdata, rdata_d, rdata_q;
  logic                          sel_insel, sel_mio, sel_dio, sel_wkup;
  logic                          sel_cause, sel_status, sel_sleep_en;
  logic [NPeriphIn-1:0][SelW-1:0] insel_q;
  mio_pad_cfg_t [NMioPads-1:0]   mio_cfg_q;
  dio_pad_cfg_t [NDioPads-1:0]   dio_cfg_q;
  wkup_cfg_t [NWkupDetect-1:0]   wkup_cfg_q;
  logic [NPads-1:0]              status_q, status_clr;

  ////////////////////////////////////////
  // Handshake and decode
  ////////////////////////////////////////

  // New request seen while ack is low
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_en  = access & wb_req_i.we;
  // Word aligned address and array index
  assign adr    = {wb_req_i.adr[7:2], 2'b00};
  assign idx    = adr[5:2];
  assign wdata  = wb_req_i.dat;

  // Single words first, they sit inside the wakeup region
  assign sel_cause    = (adr == WkupCauseAddr);
  assign sel_status   = (adr == SleepStatusAddr);
  assign sel_sleep_en = (adr == SleepEnAddr);
  assign sel_insel = (adr[7:6] == MioInselBase[7:6]) && (int'(idx) < NPeriphIn);
  assign sel_mio   = (adr[7:6] == MioPadBase[7:6]) && (int'(idx) < NMioPads);
  assign sel_dio   = (adr[7:6] == DioPadBase[7:6]) && (int'(idx) < NDioPads);
  assign sel_wkup  = (adr[7:6] == WkupBase[7:6]) && (int'(idx) < NWkupDetect) &&
                     !sel_cause && !sel_status && !sel_sleep_en;

  // Write-one-to-clear pulses
  assign wkup_clr_o = (wr_en && sel_cause) ? wdata[NWkupDetect-1:0] : '0;
  assign status_clr = (wr_en && sel_status) ? wdata[NPads-1:0] : '0;

  // Read mux, unmapped words read zero
  always_comb begin
    rdata_d = '0;
    if (sel_cause)         rdata_d = 32'(wkup_cause_i);
    else if (sel_status)   rdata_d = 32'(status_q);
    else if (sel_sleep_en) rdata_d = {31'b0, sleep_en_i};
    else if (sel_insel)    rdata_d = 32'(insel_q[idx]);
    else if (sel_mio)      rdata_d = 32'(mio_cfg_q[idx]);
    else if (sel_dio)      rdata_d = 32'(dio_cfg_q[idx]);
    else if (sel_wkup)     rdata_d = 32'(wkup_cfg_q[idx]);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      // One cycle ack per request
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

  ////////////////////////////////////////
  // Configuration storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insel_q    <= '0;
      mio_cfg_q  <= '0;
      dio_cfg_q  <= '0;
      wkup_cfg_q <= '0;
      status_q   <= '0;
    end else begin
      if (wr_en && sel_insel) insel_q[idx] <= wdata[SelW-1:0];
      if (wr_en && sel_mio) mio_cfg_q[idx] <= mio_pad_cfg_t'(wdata[$bits(mio_pad_cfg_t)-1:0]);
      if (wr_en && sel_dio) dio_cfg_q[idx] <= dio_pad_cfg_t'(wdata[$bits(dio_pad_cfg_t)-1:0]);
      if (wr_en && sel_wkup) wkup_cfg_q[idx] <= wkup_cfg_t'(wdata[$bits(wkup_cfg_t)-1:0]);
      // Set beats clear
      status_q <= (status_q & ~status_clr) | {dio_sleep_set_i, mio_sleep_set_i};
    end
  end

  assign insel_o        = insel_q;
  assign mio_cfg_o      = mio_cfg_q;
  assign dio_cfg_o      = dio_cfg_q;
  assign wkup_cfg_o     = wkup_cfg_q;
  assign sleep_status_o = status_q;

endmodule

`default_nettype wire

/* hdl/pinmux_wkup.sv */
// Wakeup detector with pin synchroniser, glitch filter, edge and timed modes
`default_nettype none

module pinmux_wkup
  import pinmux_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  wkup_cfg_t cfg_i,
  input  logic      pin_value_i,
  input  logic      cause_clr_i,
  output logic      cause_o
);

  // Stable cycles before the filter takes a new level
  localparam logic [1:0] FiltLast = 2'd3;

  logic [1:0]      sync_q, filt_cnt_q;
  logic            cand_q, filt_q, pin, pin_q;
  logic            level, det;
  logic [CntW-1:0] cnt_q;
  logic            cause_q;

  assign pin   = cfg_i.filter ? filt_q : sync_q[1];
  // Level counted in the timed modes
  assign level = (cfg_i.mode == WkupTimedHigh) ? pin : ~pin;

  always_comb begin
    case (cfg_i.mode)
      WkupPosedge:   det = pin & ~pin_q;
      WkupNegedge:   det = ~pin & pin_q;
      WkupEdge:      det = pin ^ pin_q;
      WkupTimedHigh,
      WkupTimedLow:  det = level && (cnt_q >= cfg_i.cnt_th);
      default:       det = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q     <= '0;
      cand_q     <= 1'b0;
      filt_cnt_q <= '0;
      filt_q     <= 1'b0;
      pin_q      <= 1'b0;
      cnt_q      <= '0;
      cause_q    <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], pin_value_i};
      // Restart on any change, accept after four equal samples
      if (sync_q[1] != cand_q) begin
        cand_q     <= sync_q[1];
        filt_cnt_q <= '0;
      end else if (filt_cnt_q == FiltLast) begin
        filt_q <= cand_q;
      end else begin
        filt_cnt_q <= filt_cnt_q + 2'd1;
      end
      pin_q <= pin;
      // Consecutive cycles at the level, saturating
      if (!level || !cfg_i.en) cnt_q <= '0;
      else if (cnt_q != '1) cnt_q <= cnt_q + 1'b1;
      // Sticky cause, set wins
      if (cfg_i.en && det) cause_q <= 1'b1;
      else if (cause_clr_i) cause_q <= 1'b0;
    end
  end

  assign cause_o = cause_q;

endmodule

`default_nettype wire

/* pinmux.f */
hdl/pinmux_bus_pkg.sv
hdl/pinmux_pkg.sv
hdl/pinmux_regs.sv
hdl/pinmux_pad_mux.sv
hdl/pinmux_wkup.sv
hdl/pinmux.sv
verification/pinmux_sva.sv
verification/pinmux_tb.sv

/* verification/pinmux_sva.sv */
// Bus handshake and pad enable assertions bound into the pad multiplexer
`default_nettype none

module pinmux_sva
  import pinmux_bus_pkg::*;
#(
  parameter int NMioPads = 8,
  parameter int NDioPads = 4
) (
  input logic                clk_i,
  input logic                rst_ni,
  input wb_req_t             wb_req_i,
  input wb_rsp_t             wb_rsp_o,
  input logic [NMioPads-1:0] mio_oe_o,
  input logic [NDioPads-1:0] dio_oe_o
);

  // Ack answers a request seen on the previous edge
  ack_on_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
    else $error("ack without a pending request");

  // Single cycle ack
  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_o.ack |=> !wb_rsp_o.ack)
    else $error("ack held for two cycles");

  oe_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(mio_oe_o) && !$isunknown(dio_oe_o))
    else $error("pad output enable unknown");

endmodule

bind pinmux pinmux_sva #(
  .NMioPads (NMioPads),
  .NDioPads (NDioPads)
) u_sva (
  .clk_i,
  .rst_ni,
  .wb_req_i,
  .wb_rsp_o,
  .mio_oe_o,
  .dio_oe_o
);

`default_nettype wire

/* verification/pinmux_tb.sv */
// Pad multiplexer testbench with bus tasks, reference model, output compare and watchdog
`default_nettype none

module pinmux_tb
  import pinmux_bus_pkg::*;
  import pinmux_pkg::*;
;

  localparam int NMio = 8;
  localparam int NDio = 4;
  localparam int NIn = 6;
  localparam int NOut = 6;
  localparam int NWk = 2;
  localparam int Period = 40;

  logic clk_i, rst_ni, sleep_en, aon_wkup;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic [NOut-1:0] p2m, p2m_oe;
  logic [NIn-1:0] m2p;
  logic [NDio-1:0] p2d, p2d_oe, d2p, dio_out, dio_oe, dio_in;
  logic [NMio-1:0] mio_out, mio_oe, mio_in;
  logic [NMio-1:0][AttrW-1:0] mio_attr;
  logic [NDio-1:0][AttrW-1:0] dio_attr;

  // Shadow copy of the configuration
  logic [SelW-1:0] insel_sh [NIn];
  mio_pad_cfg_t mio_sh [NMio];
  dio_pad_cfg_t dio_sh [NDio];
  wkup_cfg_t wk_sh [NWk];
  logic [NMio+NDio-1:0] status_sh;
  logic [1:0] ret_sh [NMio+NDio];
  logic [NWk-1:0] cause_sh;
  logic cmp_en;
  int errors;
  integer seed;

  pinmux u_dut (
    .clk_i, .rst_ni, .sleep_en_i(sleep_en), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
    .periph_to_mio_i(p2m), .periph_to_mio_oe_i(p2m_oe), .mio_to_periph_o(m2p),
    .periph_to_dio_i(p2d), .periph_to_dio_oe_i(p2d_oe), .dio_to_periph_o(d2p),
    .mio_out_o(mio_out), .mio_oe_o(mio_oe), .mio_attr_o(mio_attr), .mio_in_i(mio_in),
    .dio_out_o(dio_out), .dio_oe_o(dio_oe), .dio_attr_o(dio_attr), .dio_in_i(dio_in),
    .aon_wkup_req_o(aon_wkup)
  );

  always #(Period / 2) clk_i = ~clk_i;

  // Watchdog
  initial begin
    #(20000 * Period);
    $display("Timeout: run exceeded 20000 cycles with %0d errors", errors);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Live {oe, out} of pad p, dedicated pads above the muxed ones
  function automatic logic [1:0] live_pad(int p);
    int j;
    if (p >= NMio) return {p2d_oe[p-NMio], p2d[p-NMio]};
    j = int'(mio_sh[p].outsel) - 3;
    case (mio_sh[p].outsel)
      4'd0: return 2'b00;
      4'd1: return 2'b10;
      4'd2: return 2'b11;
      default: return (j < NOut) ? {p2m_oe[j], p2m[j]} : 2'b00;
    endcase
  endfunction

  function automatic logic [1:0] pad_exp(int p);
    return status_sh[p] ? ret_sh[p] : live_pad(p);
  endfunction

  function automatic logic periph_exp(int k);
    int j;
    j = int'(insel_sh[k]) - 2;
    if (insel_sh[k] == 4'd1) return 1'b1;
    if (insel_sh[k] >= 4'd2 && j < NMio) return mio_in[j];
    return 1'b0;
  endfunction

  function automatic logic [1:0] retain(sleep_mode_e mode, logic [1:0] live);
    case (mode)
      SleepLow:   return 2'b10;
      SleepHigh:  return 2'b11;
      SleepHighZ: return 2'b00;
      default:    return live;
    endcase
  endfunction

  function automatic logic [31:0] read_exp(logic [7:0] adr);
    int i;
    i = int'(adr[5:2]);
    if (adr == WkupCauseAddr) return 32'(cause_sh);
    if (adr == SleepStatusAddr) return 32'(status_sh);
    if (adr == SleepEnAddr) return 32'(sleep_en);
    if (adr[7:6] == 2'd0 && i < NIn) return 32'(insel_sh[i]);
    if (adr[7:6] == 2'd1 && i < NMio) return 32'(mio_sh[i]);
    if (adr[7:6] == 2'd2 && i < NDio) return 32'(dio_sh[i]);
    if (adr[7:6] == 2'd3 && i < NWk) return 32'(wk_sh[i]);
    return 32'h0;
  endfunction

  task automatic shadow_write(logic [7:0] adr, logic [31:0] d);
    int i;
    i = int'(adr[5:2]);
    if (adr == WkupCauseAddr) cause_sh &= ~d[NWk-1:0];
    else if (adr == SleepStatusAddr) status_sh &= ~d[NMio+NDio-1:0];
    else if (adr[7:6] == 2'd0 && i < NIn) insel_sh[i] = d[3:0];
    else if (adr[7:6] == 2'd1 && i < NMio) mio_sh[i] = d[10:0];
    else if (adr[7:6] == 2'd2 && i < NDio) dio_sh[i] = d[6:0];
    else if (adr[7:6] == 2'd3 && i < NWk) wk_sh[i] = d[18:0];
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  task automatic check_val(string name, int idx, logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s[%0d] got %h exp %h", $time, name, idx, got, exp);
    end
  endtask

  // Sampled a quarter period after the falling edge
  always begin
    logic [1:0] e;
    @(negedge clk_i);
    #(Period / 4);
    if (cmp_en) begin
      for (int k = 0; k < NMio; k++) begin
        e = pad_exp(k);
        check_val("mio_out_o", k, 4'(mio_out[k]), 4'(e[0]));
        check_val("mio_oe_o", k, 4'(mio_oe[k]), 4'(e[1]));
        check_val("mio_attr_o", k, mio_attr[k], mio_sh[k].attr);
      end
      for (int k = 0; k < NDio; k++) begin
        e = pad_exp(NMio + k);
        check_val("dio_out_o", k, 4'(dio_out[k]), 4'(e[0]));
        check_val("dio_oe_o", k, 4'(dio_oe[k]), 4'(e[1]));
        check_val("dio_attr_o", k, dio_attr[k], dio_sh[k].attr);
        check_val("dio_to_periph_o", k, 4'(d2p[k]), 4'(dio_in[k]));
      end
      for (int k = 0; k < NIn; k++) begin
        check_val("mio_to_periph_o", k, 4'(m2p[k]), 4'(periph_exp(k)));
      end
    end
  end

  ////////////////////////////////////////
  // Bus and stimulus tasks
  ////////////////////////////////////////

  task automatic wb_access(logic we, logic [7:0] adr, logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    @(negedge clk_i);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    n = 0;
    rdat = '0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!wb_rsp.ack && n < 16);
    if (!wb_rsp.ack) begin
      errors++;
      $display("Error at %0t: no ack for address %h", $time, adr);
    end else begin
      rdat = wb_rsp.dat;
      if (we) shadow_write(adr, wdat);
    end
    wb_req = '0;
  endtask

  task automatic wb_write(logic [7:0] adr, logic [31:0] d);
    logic [31:0] unused;
    wb_access(1'b1, adr, d, unused);
  endtask

  task automatic read_check(logic [7:0] adr);
    logic [31:0] d;
    wb_access(1'b0, adr, '0, d);
    if (d !== read_exp(adr)) begin
      errors++;
      $display("[FAIL] %0t wb_rsp_o.dat@%h got %h exp %h", $time, adr, d, read_exp(adr));
    end
  endtask

  task automatic randomize_inputs();
    p2m = $random(seed);
    p2m_oe = $random(seed);
    p2d = $random(seed);
    p2d_oe = $random(seed);
    mio_in = $random(seed);
    dio_in = $random(seed);
  endtask

  function automatic logic [31:0] wkup_word(logic en, wkup_mode_e m, logic filt, logic [3:0] pad,
                                            logic [7:0] th);
    return {14'b0, th, pad, 1'b0, filt, m, en};
  endfunction

  task automatic expect_no_wkup(int n);
    repeat (n) begin
      @(negedge clk_i);
      check_val("aon_wkup_req_o", 0, 4'(aon_wkup), 4'd0);
    end
  endtask

  task automatic wait_wkup(int det, int limit);
    int n;
    n = 0;
    while (!aon_wkup && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (!aon_wkup) begin
      errors++;
      $display("Error at %0t: wakeup request of detector %0d never rose", $time, det);
    end
    cause_sh[det] = 1'b1;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [7:0] adr;
    logic [31:0] d;
    logic [3:0] sel;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    sleep_en = 1'b0;
    wb_req = '0;
    p2m = '0;
    p2m_oe = '0;
    p2d = '0;
    p2d_oe = '0;
    mio_in = '0;
    dio_in = '0;
    cmp_en = 1'b0;
    errors = 0;
    seed = 32'h5789aa8e;
    foreach (insel_sh[k]) insel_sh[k] = '0;
    foreach (mio_sh[k]) mio_sh[k] = '0;
    foreach (dio_sh[k]) dio_sh[k] = '0;
    foreach (wk_sh[k]) wk_sh[k] = '0;
    foreach (ret_sh[k]) ret_sh[k] = '0;
    status_sh = '0;
    cause_sh = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    cmp_en = 1'b1;

    // Register readback, wakeup detectors kept disabled
    repeat (80) begin
      adr = $random(seed) & 8'hFC;
      d = $random(seed);
      if (adr[7:6] == 2'd3 && adr < WkupCauseAddr) d[0] = 1'b0;
      wb_write(adr, d);
      read_check(adr);
    end
    read_check(8'h18);
    read_check(8'h60);
    read_check(8'h90);
    read_check(8'hC8);
    read_check(8'hFC);

    // Output and input select muxes
    repeat (60) begin
      wb_write(MioPadBase + 8'(4 * ({$random(seed)} % NMio)), $random(seed) & 32'h7EF);
      wb_write(MioInselBase + 8'(4 * ({$random(seed)} % NIn)), $random(seed));
      wb_write(DioPadBase + 8'(4 * ({$random(seed)} % NDio)), $random(seed) & 32'h7E);
      repeat (3) begin
        @(negedge clk_i);
        randomize_inputs();
      end
    end

    // Sleep entry and retention in every mode
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < NMio; k++) begin
        sel = 4'({$random(seed)} % 9);
        d = (($random(seed) & 32'hF) << 7) | (m << 5) | (($random(seed) & 1) << 4) | sel;
        wb_write(MioPadBase + 8'(4 * k), d);
      end
      for (int k = 0; k < NDio; k++) begin
        wb_write(DioPadBase + 8'(4 * k), (($random(seed) & 32'hF) << 3) | (m << 1) |
                                         ($random(seed) & 1));
      end
      @(negedge clk_i);
      randomize_inputs();
      @(negedge clk_i);
      for (int p = 0; p < NMio + NDio; p++) begin
        ret_sh[p] = retain(sleep_mode_e'(m), live_pad(p));
      end
      sleep_en = 1'b1;
      // Registered edge, then capture on the following edge
      repeat (2) @(negedge clk_i);
      for (int k = 0; k < NMio; k++) status_sh[k] = mio_sh[k].sleep_en;
      for (int k = 0; k < NDio; k++) status_sh[NMio+k] = dio_sh[k].sleep_en;
      repeat (6) begin
        @(negedge clk_i);
        randomize_inputs();
      end
      read_check(SleepStatusAddr);
      read_check(SleepEnAddr);
      sleep_en = 1'b0;
      wb_write(SleepStatusAddr, 32'hFFF);
      read_check(SleepStatusAddr);
      repeat (4) begin
        @(negedge clk_i);
        randomize_inputs();
      end
    end

    // Posedge wakeup through the filter
    @(negedge clk_i);
    mio_in = '0;
    dio_in = '0;
    // Synchroniser and filter settle low first
    repeat (10) @(negedge clk_i);
    wb_write(WkupBase, wkup_word(1'b1, WkupPosedge, 1'b1, 4'd3, 8'd0));
    expect_no_wkup(8);
    mio_in[3] = 1'b1;
    wait_wkup(0, 40);
    read_check(WkupCauseAddr);
    mio_in[3] = 1'b0;
    repeat (10) @(negedge clk_i);
    wb_write(WkupCauseAddr, 32'h1);
    expect_no_wkup(1);
    read_check(WkupCauseAddr);
    wb_write(WkupBase, 32'h0);

    // Timed high, short pulse must not fire
    wb_write(WkupBase + 8'd4, wkup_word(1'b1, WkupTimedHigh, 1'b0, 4'd5, 8'd10));
    expect_no_wkup(4);
    mio_in[5] = 1'b1;
    expect_no_wkup(5);
    mio_in[5] = 1'b0;
    expect_no_wkup(30);
    mio_in[5] = 1'b1;
    expect_no_wkup(10);
    wait_wkup(1, 20);
    read_check(WkupCauseAddr);
    mio_in[5] = 1'b0;
    repeat (6) @(negedge clk_i);
    wb_write(WkupCauseAddr, 32'h2);
    expect_no_wkup(1);
    read_check(WkupCauseAddr);
    wb_write(WkupBase + 8'd4, 32'h0);

    // Disabled detector sees edges but stays quiet
    wb_write(WkupBase, wkup_word(1'b0, WkupEdge, 1'b0, 4'd2, 8'd0));
    repeat (6) begin
      mio_in[2] = ~mio_in[2];
      expect_no_wkup(4);
    end
    read_check(WkupCauseAddr);

    repeat (4) @(negedge clk_i);
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
